//--- pbch_llr_path.f
source/pbch_rx_pkg.sv
source/qpsk_demapper.sv
source/pbch_block_framer.sv
source/pbch_llr_fifo.sv
source/pbch_llr_path.sv
verification/tb_clock_gen.sv
verification/pbch_llr_path_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the PBCH LLR path testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module pbch_llr_path_tb \
    -f pbch_llr_path.f \
    -o pbch_llr_path_sim
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

output=$(./obj_dir/pbch_llr_path_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All tests passed"; then
    exit 0
fi
echo "pass message not found"
exit 1

//--- source/pbch_block_framer.sv
`timescale 1ns/100ps

module pbch_block_framer
    import pbch_rx_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_ni,

    input  llr_pair_t   llr_i,
    input  logic        llr_valid_i,

    output pbch_entry_t entry_o,
    output logic        push_o
);

    logic [SYM_IDX_W-1:0] sym_idx;
    logic [BLK_IDX_W-1:0] blk_idx;
    logic                 is_pbch;

    assign is_pbch = llr_valid_i && (llr_i.kind == SYM_PBCH);

    // ----------------------------------------------------------------------
    // symbol and block counters
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sym_idx <= '0;
            blk_idx <= '0;
        end else if (is_pbch) begin
            if (llr_i.last) begin
                sym_idx <= '0;
                // wraps after 16 blocks
                blk_idx <= blk_idx + 1'b1;
            end else begin
                sym_idx <= sym_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            push_o <= 1'b0;
        end else begin
            push_o <= is_pbch;
        end
    end

    // entry carries the index before the update
    always_ff @(posedge clk_i) begin
        if (is_pbch) begin
            entry_o.llr_i   <= llr_i.llr_i;
            entry_o.llr_q   <= llr_i.llr_q;
            entry_o.sym_idx <= sym_idx;
            entry_o.blk_idx <= blk_idx;
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    push_follows_valid: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        $rose(push_o) |-> $past(llr_valid_i)
    );

endmodule

//--- source/pbch_llr_fifo.sv
`timescale 1ns/100ps

module pbch_llr_fifo
    import pbch_rx_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
)
(
    input  logic                          clk_i,
    input  logic                          reset_ni,

    input  pbch_entry_t                   entry_i,
    input  logic                          push_i,
    input  logic                          pop_i,

    output pbch_entry_t                   entry_o,
    output logic                          entry_valid_o,
    output logic [$clog2(FIFO_DEPTH):0]   level_o,
    output logic                          overflow_o
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    pbch_entry_t       mem [FIFO_DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;

    logic empty;
    logic full;
    logic do_pop;
    logic do_push;

    assign empty   = (count == '0);
    assign full    = (count == FIFO_DEPTH[ADDR_W:0]);
    assign do_pop  = pop_i && !empty;
    // a pop on a full FIFO frees the slot for this push
    assign do_push = push_i && (!full || do_pop);

    // ----------------------------------------------------------------------
    // storage
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= entry_i;
        end
    end

    // pointers and level
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // sticky until reset
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            overflow_o <= 1'b0;
        end else if (push_i && !do_push) begin
            overflow_o <= 1'b1;
        end
    end

    // show-ahead read
    assign entry_o       = mem[rd_ptr];
    assign entry_valid_o = !empty;
    assign level_o       = count;

    level_bound: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        level_o <= FIFO_DEPTH
    );

endmodule

//--- source/pbch_llr_path.sv
`timescale 1ns/100ps

module pbch_llr_path
    import pbch_rx_pkg::*;
#(
    parameter int LLR_GAIN_SHIFT = 2,
    parameter int FIFO_DEPTH     = 16
)
(
    input  logic                          clk_i,
    input  logic                          reset_ni,

    input  iq_sym_t                       sym_i,
    input  logic                          sym_valid_i,
    input  logic                          pop_i,

    output pbch_entry_t                   entry_o,
    output logic                          entry_valid_o,
    output logic [$clog2(FIFO_DEPTH):0]   level_o,
    output logic                          overflow_o
);

    llr_pair_t   llr;
    logic        llr_valid;
    pbch_entry_t framed;
    logic        push;

    // ----------------------------------------------------------------------
    // demap, frame, store
    // ----------------------------------------------------------------------
    qpsk_demapper #(
        .LLR_GAIN_SHIFT(LLR_GAIN_SHIFT)
    ) qpsk_demapper_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .sym_i       (sym_i),
        .sym_valid_i (sym_valid_i),
        .llr_o       (llr),
        .llr_valid_o (llr_valid)
    );

    pbch_block_framer pbch_block_framer_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .llr_i       (llr),
        .llr_valid_i (llr_valid),
        .entry_o     (framed),
        .push_o      (push)
    );

    pbch_llr_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) pbch_llr_fifo_i (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .entry_i       (framed),
        .push_i        (push),
        .pop_i         (pop_i),
        .entry_o       (entry_o),
        .entry_valid_o (entry_valid_o),
        .level_o       (level_o),
        .overflow_o    (overflow_o)
    );

endmodule

//--- source/pbch_rx_pkg.sv
package pbch_rx_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    localparam int IQ_W      = 8;
    localparam int LLR_W     = 8;
    localparam int SYM_IDX_W = 8;
    localparam int BLK_IDX_W = 4;

    // symbol type tag from the resource grid
    typedef enum logic [1:0] {
        SYM_DATA = 2'd0,
        SYM_PBCH = 2'd1,
        SYM_SSS  = 2'd2,
        SYM_DMRS = 2'd3
    } sym_type_e;

    // ----------------------------------------------------------------------
    // payload structs
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic signed [IQ_W-1:0] re;
        logic signed [IQ_W-1:0] im;
        sym_type_e              kind;
        logic                   last;   // final symbol of a block
    } iq_sym_t;

    typedef struct packed {
        logic signed [LLR_W-1:0] llr_i;
        logic signed [LLR_W-1:0] llr_q;
        sym_type_e               kind;
        logic                    last;
    } llr_pair_t;

    // one FIFO word as seen by software
    typedef struct packed {
        logic signed [LLR_W-1:0] llr_i;
        logic signed [LLR_W-1:0] llr_q;
        logic [SYM_IDX_W-1:0]    sym_idx;
        logic [BLK_IDX_W-1:0]    blk_idx;
    } pbch_entry_t;

endpackage

//--- source/qpsk_demapper.sv
`timescale 1ns/100ps

module qpsk_demapper
    import pbch_rx_pkg::*;
#(
    parameter int LLR_GAIN_SHIFT = 2
)
(
    input  logic      clk_i,
    input  logic      reset_ni,

    input  iq_sym_t   sym_i,
    input  logic      sym_valid_i,

    output llr_pair_t llr_o,
    output logic      llr_valid_o
);

    // headroom so the shift cannot wrap before saturation
    localparam int WIDE_W = IQ_W + LLR_GAIN_SHIFT;

    localparam logic signed [WIDE_W-1:0] LLR_MAX = (1 <<< (LLR_W - 1)) - 1;
    localparam logic signed [WIDE_W-1:0] LLR_MIN = -(1 <<< (LLR_W - 1));

    // scale one component and clip to the LLR range
    function automatic logic signed [LLR_W-1:0] scale_sat(input logic signed [IQ_W-1:0] x);
        logic signed [WIDE_W-1:0] wide;
        wide = x;
        wide = wide <<< LLR_GAIN_SHIFT;
        if (wide > LLR_MAX) begin
            return LLR_MAX[LLR_W-1:0];
        end else if (wide < LLR_MIN) begin
            return LLR_MIN[LLR_W-1:0];
        end
        return wide[LLR_W-1:0];
    endfunction

    // ----------------------------------------------------------------------
    // output register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            llr_valid_o <= 1'b0;
        end else begin
            llr_valid_o <= sym_valid_i;
        end
    end

    // payload
    always_ff @(posedge clk_i) begin
        if (sym_valid_i) begin
            llr_o.llr_i <= scale_sat(sym_i.re);
            llr_o.llr_q <= scale_sat(sym_i.im);
            llr_o.kind  <= sym_i.kind;
            llr_o.last  <= sym_i.last;
        end
    end

endmodule

//--- verification/pbch_llr_path_tb.sv
`timescale 1ns/100ps

module pbch_llr_path_tb
    import pbch_rx_pkg::*;
;

    localparam int GAIN_SHIFT = 2;
    localparam int DEPTH      = 16;
    // stimulus and draining need roughly 300 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic                      clk_i;
    logic                      gen_reset_n;
    logic                      tb_reset_n;
    logic                      reset_ni;
    iq_sym_t                   sym_i;
    logic                      sym_valid_i;
    logic                      pop_i;
    pbch_entry_t               entry_o;
    logic                      entry_valid_o;
    logic [$clog2(DEPTH):0]    level_o;
    logic                      overflow_o;

    pbch_entry_t expected_q[$];
    pbch_entry_t exp_entry;
    logic [SYM_IDX_W-1:0] model_sym_idx;
    logic [BLK_IDX_W-1:0] model_blk_idx;
    int          error_count;
    int          cycle_count;
    int          pop_mode;   // 0 none, 1 follow valid, 2 held high
    integer      seed;
    string       test_name;

    assign reset_ni = gen_reset_n & tb_reset_n;

    tb_clock_gen clock_gen_i (
        .clk_o    (clk_i),
        .reset_no (gen_reset_n)
    );

    pbch_llr_path #(
        .LLR_GAIN_SHIFT(GAIN_SHIFT),
        .FIFO_DEPTH    (DEPTH)
    ) dut_i (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .sym_i         (sym_i),
        .sym_valid_i   (sym_valid_i),
        .pop_i         (pop_i),
        .entry_o       (entry_o),
        .entry_valid_o (entry_valid_o),
        .level_o       (level_o),
        .overflow_o    (overflow_o)
    );

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    function automatic logic signed [LLR_W-1:0] ref_llr(input logic signed [IQ_W-1:0] x);
        integer v;
        v = x;
        v = v * (1 << GAIN_SHIFT);
        if (v > 127) begin
            v = 127;
        end else if (v < -128) begin
            v = -128;
        end
        return v[LLR_W-1:0];
    endfunction

    function automatic pbch_entry_t ref_entry(input iq_sym_t s, input logic [SYM_IDX_W-1:0] sidx,
                                              input logic [BLK_IDX_W-1:0] bidx);
        pbch_entry_t e;
        e.llr_i   = ref_llr(s.re);
        e.llr_q   = ref_llr(s.im);
        e.sym_idx = sidx;
        e.blk_idx = bidx;
        return e;
    endfunction

    // drive one symbol and record what should come out
    task automatic send_sym(input logic [7:0] re, input logic [7:0] im,
                            input sym_type_e kind, input logic last);
        iq_sym_t s;
        s.re   = re;
        s.im   = im;
        s.kind = kind;
        s.last = last;
        @(posedge clk_i);
        #10;
        sym_i       = s;
        sym_valid_i = 1'b1;
        if (kind == SYM_PBCH) begin
            expected_q.push_back(ref_entry(s, model_sym_idx, model_blk_idx));
            if (last) begin
                model_sym_idx = '0;
                model_blk_idx = model_blk_idx + 1'b1;
            end else begin
                model_sym_idx = model_sym_idx + 1'b1;
            end
        end
    endtask

    task automatic stop_input();
        @(posedge clk_i);
        #10;
        sym_valid_i = 1'b0;
    endtask

    task automatic wait_drained();
        repeat (4) @(posedge clk_i);
        while (expected_q.size() != 0 || entry_valid_o) @(posedge clk_i);
    endtask

    // pop driver
    always @(posedge clk_i) begin
        #10;
        case (pop_mode)
            1:       pop_i = entry_valid_o;
            2:       pop_i = 1'b1;
            default: pop_i = 1'b0;
        endcase
    end

    // compare popped entries at the falling edge
    always @(negedge clk_i) begin
        if (reset_ni && pop_i && entry_valid_o) begin
            if (expected_q.size() == 0) begin
                error_count++;
                $display("[%s] DUT delivered an entry that was never expected", test_name);
            end else begin
                exp_entry = expected_q.pop_front();
                if (entry_o !== exp_entry) begin
                    error_count++;
                    $display("** Error [%s] expected %h actual %h", test_name, exp_entry, entry_o);
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, DUT stopped delivering entries", cycle_count);
            $display("errors: %0d", error_count);
            $display("Some tests failed");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    initial begin
        logic signed [7:0] sat_vals [7];
        logic [31:0]       rnd;
        int                len;
        sat_vals = '{-8'sd128, -8'sd33, -8'sd32, 8'sd0, 8'sd31, 8'sd32, 8'sd127};
        sym_i = '0;
        sym_valid_i = 1'b0;
        pop_i = 1'b0;
        tb_reset_n = 1'b1;
        pop_mode = 0;
        error_count = 0;
        cycle_count = 0;
        seed = 22;
        model_sym_idx = '0;
        model_blk_idx = '0;
        test_name = "saturation";
        @(posedge reset_ni);
        pop_mode = 1;
        for (int k = 0; k < 7; k++) begin
            send_sym(sat_vals[k], sat_vals[6-k], SYM_PBCH, 1'b0);
        end
        stop_input();
        wait_drained();

        test_name = "filtering";
        for (int k = 0; k < 60; k++) begin
            rnd = $random(seed);
            send_sym(rnd[7:0], rnd[15:8], sym_type_e'(rnd[17:16]), rnd[20:18] == 3'd0);
        end
        stop_input();
        wait_drained();

        test_name = "indexing";
        for (int b = 0; b < 18; b++) begin
            rnd = $random(seed);
            len = 1 + rnd[1:0];
            for (int k = 0; k < len; k++) begin
                send_sym(rnd[15:8] + k, rnd[23:16] - k, SYM_PBCH, k == len - 1);
            end
        end
        stop_input();
        wait_drained();

        test_name = "overflow";
        pop_mode = 0;
        for (int k = 0; k < 20; k++) begin
            rnd = $random(seed);
            send_sym(rnd[7:0], rnd[15:8], SYM_PBCH, 1'b0);
        end
        stop_input();
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        if (level_o !== DEPTH) begin
            error_count++;
            $display("** Error [%s] expected %0d actual %0d", test_name, DEPTH, level_o);
        end
        if (overflow_o !== 1'b1) begin
            error_count++;
            $display("** Error [%s] expected %b actual %b", test_name, 1'b1, overflow_o);
        end
        // the last four pushes were dropped
        repeat (4) void'(expected_q.pop_back());
        pop_mode = 1;
        wait_drained();

        test_name = "push_pop";
        pop_mode = 0;
        // leave entries in the FIFO and nonzero counters for the reset to clear
        for (int k = 0; k < 3; k++) begin
            rnd = $random(seed);
            send_sym(rnd[7:0], rnd[15:8], SYM_PBCH, 1'b0);
        end
        stop_input();
        repeat (4) @(posedge clk_i);
        expected_q.delete();
        @(posedge clk_i);
        #10;
        tb_reset_n = 1'b0;
        repeat (4) @(posedge clk_i);
        #10;
        tb_reset_n = 1'b1;
        model_sym_idx = '0;
        model_blk_idx = '0;
        @(negedge clk_i);
        if (entry_valid_o !== 1'b0 || level_o !== '0 || overflow_o !== 1'b0) begin
            error_count++;
            $display("** Error [%s] expected %b/%0d/%b actual %b/%0d/%b", test_name,
                     1'b0, 0, 1'b0, entry_valid_o, level_o, overflow_o);
        end
        pop_mode = 2;
        for (int k = 0; k < 30; k++) begin
            rnd = $random(seed);
            send_sym(rnd[7:0], rnd[15:8], SYM_PBCH, k % 7 == 6);
            @(negedge clk_i);
            if (level_o > 1) begin
                error_count++;
                $display("** Error [%s] expected %0d actual %0d", test_name, 1, level_o);
            end
        end
        stop_input();
        wait_drained();

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 4
)
(
    output logic clk_o,
    output logic reset_no
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // release shortly after an edge, like the other inputs
    initial begin
        reset_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #10;
        reset_no = 1'b1;
    end

endmodule
